// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpuCore_tb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/cpuCore_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore_properties (
    input logic        clk,
    input logic        rstN,
    input logic        memValid,
    input logic        memReady,
    input logic [15:0] memAddr,
    input logic        memWrite,
    input logic [7:0]  memWData,
    input logic        sync
);

    int failCount = 0;

    // a stalled request holds until memory takes it
    assert property (@(posedge clk) disable iff (!rstN)
        memValid && !memReady |=> $stable(memAddr) && $stable(memWrite) && $stable(memWData))
    else begin
        failCount = failCount + 1;
        $error("memory request changed while stalled");
    end

    assert property (@(posedge clk) !rstN |-> !memValid && !memWrite)
    else begin
        failCount = failCount + 1;
        $error("memValid or memWrite high during reset");
    end

    // opcode fetches are always reads
    assert property (@(posedge clk) disable iff (!rstN) sync |-> !memWrite)
    else begin
        failCount = failCount + 1;
        $error("write issued during an opcode fetch");
    end

endmodule

bind cpuCore cpuCore_properties props (.*);

`default_nettype wire

// File: bench/cpuCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore_tb import cpuPkg::*; ();

    localparam logic [15:0] startPc = 16'hC000;
    localparam int numRows = 17;
    localparam int maxWait = 40;

    typedef struct packed {
        logic [7:0]  op;
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic [1:0]  len;
        logic [2:0]  cyc;
        logic        wr;
        logic [15:0] dAddr;
        logic [7:0]  dVal;
        logic [7:0]  accE;
        logic [7:0]  xE;
        logic [7:0]  yE;
    } progRowT;

    logic        clk = 1'b0;
    logic        rstN = 1'b0;
    logic        memReady = 1'b0;
    logic [7:0]  memRData = 8'h00;
    logic        memValid;
    logic [15:0] memAddr;
    logic        memWrite;
    logic [7:0]  memWData;
    logic        sync;
    logic [7:0]  accOut;
    logic [7:0]  xOut;
    logic [7:0]  yOut;

    logic [7:0]  mem [0:65535];
    logic [31:0] lcgState = 32'ha618cd07;
    logic [1:0]  waitLeft = 2'd0;
    progRowT     rows [0:numRows-1];

    cpuCore #(.resetPc(startPc)) uut (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0 to 2 extra wait cycles per transfer
    function automatic logic [1:0] waitCycles(input logic [31:0] s);
        logic [15:0] r;
        r = s[31:16] % 16'd3;
        return r[1:0];
    endfunction

    task automatic abortRun();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkByte(input string name, input logic [7:0] expV, input logic [7:0] actV);
        if (expV !== actV) begin
            $display("ERROR %s expected 0x%h got 0x%h", name, expV, actV);
            abortRun();
        end
    endtask

    task automatic checkAddr(input string name, input logic [15:0] expV,
                             input logic [15:0] actV);
        if (expV !== actV) begin
            $display("ERROR %s expected 0x%h got 0x%h", name, expV, actV);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic expV, input logic actV);
        if (expV !== actV) begin
            $display("ERROR %s expected 0x%h got 0x%h", name, expV, actV);
            abortRun();
        end
    endtask

    task automatic checkWrite(input logic [15:0] expAddr, input logic [7:0] expData,
                              input logic expWr, input logic [15:0] actAddr,
                              input logic [7:0] actData, input logic actWr);
        checkAddr("memAddr", expAddr, actAddr);
        checkFlag("memWrite", expWr, actWr);
        if (expWr) begin
            checkByte("memWData", expData, actData);
        end
    endtask

    task automatic checkRegs(input progRowT row);
        checkByte("accOut", row.accE, accOut);
        checkByte("xOut", row.xE, xOut);
        checkByte("yOut", row.yE, yOut);
    endtask

    // returns the request that completed on this edge
    task automatic waitTransfer(output logic [15:0] addr, output logic [7:0] wData,
                                output logic wr, output logic syncSeen);
        int n;
        n = 0;
        @(posedge clk);
        while (!(memValid && memReady)) begin
            n++;
            if (n > maxWait) begin
                $display("timeout: no memory transfer completed in %0d cycles", maxWait);
                abortRun();
            end
            @(posedge clk);
        end
        addr = memAddr;
        wData = memWData;
        wr = memWrite;
        syncSeen = sync;
    endtask

    // op, b1, b2, len, cycles, write, data addr, data byte, then expected A, X, Y
    task automatic buildProgram();
        rows[0]  = '{opLdaImm, 8'h3C, 8'h00, 2'd2, 3'd2, 1'b0, 16'hC001, 8'h3C, 8'h3C, 8'h00, 8'h00};
        rows[1]  = '{opLdxImm, 8'h05, 8'h00, 2'd2, 3'd2, 1'b0, 16'hC003, 8'h05, 8'h3C, 8'h05, 8'h00};
        rows[2]  = '{opLdyImm, 8'hF0, 8'h00, 2'd2, 3'd2, 1'b0, 16'hC005, 8'hF0, 8'h3C, 8'h05, 8'hF0};
        rows[3]  = '{opStaZpg, 8'h80, 8'h00, 2'd2, 3'd3, 1'b1, 16'h0080, 8'h3C, 8'h3C, 8'h05, 8'hF0};
        rows[4]  = '{opLdaZpg, 8'h42, 8'h00, 2'd2, 3'd3, 1'b0, 16'h0042, 8'h9D, 8'h9D, 8'h05, 8'hF0};
        rows[5]  = '{opStaAbs, 8'h56, 8'h34, 2'd3, 3'd4, 1'b1, 16'h3456, 8'h9D, 8'h9D, 8'h05, 8'hF0};
        rows[6]  = '{opLdaAbs, 8'h34, 8'h12, 2'd3, 3'd4, 1'b0, 16'h1234, 8'h61, 8'h61, 8'h05, 8'hF0};
        rows[7]  = '{opLdaAbx, 8'hF0, 8'h12, 2'd3, 3'd4, 1'b0, 16'h12F5, 8'h7E, 8'h7E, 8'h05, 8'hF0};
        rows[8]  = '{opInx,    8'h00, 8'h00, 2'd1, 3'd2, 1'b0, 16'hC014, 8'h00, 8'h7E, 8'h06, 8'hF0};
        rows[9]  = '{opIny,    8'h00, 8'h00, 2'd1, 3'd2, 1'b0, 16'hC015, 8'h00, 8'h7E, 8'h06, 8'hF1};
        rows[10] = '{opLdxImm, 8'hFF, 8'h00, 2'd2, 3'd2, 1'b0, 16'hC016, 8'hFF, 8'h7E, 8'hFF, 8'hF1};
        rows[11] = '{opInx,    8'h00, 8'h00, 2'd1, 3'd2, 1'b0, 16'hC018, 8'h00, 8'h7E, 8'h00, 8'hF1};
        rows[12] = '{opTax,    8'h00, 8'h00, 2'd1, 3'd2, 1'b0, 16'hC019, 8'h00, 8'h7E, 8'h7E, 8'hF1};
        // F8 + 7E wraps the low byte to 76 and leaves the high byte at 20
        rows[13] = '{opLdaAbx, 8'hF8, 8'h20, 2'd3, 3'd4, 1'b0, 16'h2076, 8'h5B, 8'h5B, 8'h7E, 8'hF1};
        rows[14] = '{8'h02,    8'h00, 8'h00, 2'd1, 3'd2, 1'b0, 16'hC01D, 8'h00, 8'h5B, 8'h7E, 8'hF1};
        rows[15] = '{opNop,    8'h00, 8'h00, 2'd1, 3'd2, 1'b0, 16'hC01E, 8'h00, 8'h5B, 8'h7E, 8'hF1};
        rows[16] = '{opStaAbs, 8'h00, 8'h04, 2'd3, 3'd4, 1'b1, 16'h0400, 8'h5B, 8'h5B, 8'h7E, 8'hF1};
    endtask

    task automatic loadMemory();
        logic [15:0] pc;
        for (int i = 0; i < 65536; i++) begin
            mem[i[15:0]] = i[15:8] ^ i[7:0] ^ 8'h5A;
        end
        pc = startPc;
        for (int r = 0; r < numRows; r++) begin
            mem[pc] = rows[r[4:0]].op;
            if (rows[r[4:0]].len > 2'd1) mem[pc + 16'd1] = rows[r[4:0]].b1;
            if (rows[r[4:0]].len > 2'd2) mem[pc + 16'd2] = rows[r[4:0]].b2;
            // bytes that the loads pick up
            if (!rows[r[4:0]].wr && rows[r[4:0]].cyc > 3'd2) begin
                mem[rows[r[4:0]].dAddr] = rows[r[4:0]].dVal;
            end
            pc = pc + 16'(rows[r[4:0]].len);
        end
    endtask

    // memory model with at least one bubble after each transfer
    always @(posedge clk) begin
        if (!rstN) begin
            memReady <= 1'b0;
            waitLeft <= 2'd0;
        end else if (memValid && memReady) begin
            if (memWrite) mem[memAddr] = memWData;
            memReady <= 1'b0;
            lcgState = lcgNext(lcgState);
            waitLeft <= waitCycles(lcgState);
        end else if (memValid) begin
            if (waitLeft == 2'd0) begin
                memReady <= 1'b1;
                memRData <= mem[memAddr];
            end else begin
                waitLeft <= waitLeft - 2'd1;
            end
        end
    end

    initial begin
        logic [15:0] pc;
        logic [15:0] a;
        logic [7:0]  wd;
        logic        w;
        logic        s;
        progRowT     cur;
        progRowT     last;
        buildProgram();
        loadMemory();
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        pc = startPc;
        last = rows[0];
        for (int r = 0; r < numRows; r++) begin
            cur = rows[r[4:0]];
            waitTransfer(a, wd, w, s);
            checkAddr("fetch memAddr", pc, a);
            checkFlag("sync", 1'b1, s);
            checkFlag("memWrite", 1'b0, w);
            if (r > 0) checkRegs(last);
            for (int k = 1; k < int'(cur.cyc); k++) begin
                waitTransfer(a, wd, w, s);
                checkFlag("sync", 1'b0, s);
                if (k == int'(cur.cyc) - 1) begin
                    checkWrite(cur.dAddr, cur.dVal, cur.wr, a, wd, w);
                end else begin
                    checkAddr("operand memAddr", pc + 16'(k), a);
                    checkFlag("memWrite", 1'b0, w);
                end
            end
            pc = pc + 16'(cur.len);
            last = cur;
        end
        waitTransfer(a, wd, w, s);
        checkAddr("fetch memAddr", pc, a);
        checkFlag("sync", 1'b1, s);
        checkRegs(last);
        if (uut.props.failCount != 0) begin
            $display("%0d bus property violations reported", uut.props.failCount);
            abortRun();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: build.f
verilog/cpuPkg.sv
verilog/ctrlBusIf.sv
verilog/addrModeDecode.sv
verilog/cycleSequencer.sv
verilog/busDatapath.sv
verilog/cpuCore.sv
bench/cpuCore_properties.sv
bench/cpuCore_tb.sv

// File: verilog/addrModeDecode.sv
`timescale 1ns/1ps
`default_nettype none

module addrModeDecode import cpuPkg::*; (
    ctrlBusIf.decoder ctrl
);

    addrModeE          mode;
    logic [numFlags:0] execFlags;
    logic [numFlags:0] f;

    // next address taken from the PC incrementer
    function automatic logic [numFlags:0] addrFromPc(input logic advance);
        logic [numFlags:0] v;
        v = '0;
        v[setAdlToPcl] = 1'b1;
        v[setAdhToPch] = 1'b1;
        v[loadAbl] = 1'b1;
        v[loadAbh] = 1'b1;
        v[pcInc] = advance;
        return v;
    endfunction

    always_comb begin
        case (ctrl.opCode)
            opLdaImm, opLdxImm, opLdyImm: mode = immediate;
            opLdaZpg, opStaZpg:           mode = zeroPage;
            opLdaAbs, opStaAbs:           mode = absolute;
            opLdaAbx:                     mode = absoluteX;
            default:                      mode = implied;
        endcase
    end

    // work done on the last cycle of each instruction
    always_comb begin
        execFlags = '0;
        case (ctrl.opCode)
            opLdaImm, opLdaZpg, opLdaAbs, opLdaAbx, opLdxImm, opLdyImm: begin
                execFlags[setDbToData] = 1'b1;
                execFlags[setSbToDb] = 1'b1;
                execFlags[loadAcc] = (ctrl.opCode != opLdxImm) && (ctrl.opCode != opLdyImm);
                execFlags[loadX] = (ctrl.opCode == opLdxImm);
                execFlags[loadY] = (ctrl.opCode == opLdyImm);
            end
            opStaZpg, opStaAbs: begin
                execFlags[setDbToAcc] = 1'b1;
                execFlags[memWrite] = 1'b1;
            end
            opInx, opIny: begin
                execFlags[setDbToX] = (ctrl.opCode == opInx);
                execFlags[setDbToY] = (ctrl.opCode == opIny);
                execFlags[setInputBToDb] = 1'b1;
                execFlags[aluInc] = 1'b1;
                execFlags[setSbToAlu] = 1'b1;
                execFlags[loadX] = (ctrl.opCode == opInx);
                execFlags[loadY] = (ctrl.opCode == opIny);
            end
            opTax: begin
                execFlags[setSbToAcc] = 1'b1;
                execFlags[loadX] = 1'b1;
            end
            default: begin
                execFlags = '0;
            end
        endcase
    end

    always_comb begin
        f = '0;
        if (ctrl.state == fetch) begin
            f = addrFromPc(1'b1);
        end else if (ctrl.state == a0 && mode == zeroPage) begin
            // operand byte is the zero page address
            f[pcInc] = 1'b1;
            f[setAdlToData] = 1'b1;
            f[setAdhLow] = 1'b1;
            f[loadAbl] = 1'b1;
            f[loadAbh] = 1'b1;
        end else if (ctrl.state == a0 && (mode == absolute || mode == absoluteX)) begin
            // low byte goes to B and X to A
            f = addrFromPc(1'b1);
            f[setDbToData] = 1'b1;
            f[setInputBToDb] = 1'b1;
            f[setSbToX] = (mode == absoluteX);
            f[setInputAToSb] = (mode == absoluteX);
        end else if (ctrl.state == a1 && (mode == absolute || mode == absoluteX)) begin
            f[pcInc] = 1'b1;
            f[setAdlToAlu] = 1'b1;
            f[aluAdd] = (mode == absoluteX);
            f[setDbToData] = 1'b1;
            f[setSbToDb] = 1'b1;
            f[setAdhToSb] = 1'b1;
            f[loadAbl] = 1'b1;
            f[loadAbh] = 1'b1;
        end else begin
            // final cycle of every mode and any state that no mode reaches
            f = addrFromPc(mode == immediate) | execFlags;
            f[lastCycle] = 1'b1;
        end
    end

    assign ctrl.flags = f;

endmodule

`default_nettype wire

// File: verilog/busDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module busDatapath import cpuPkg::*; #(
    parameter logic [15:0] resetPc = 16'h0200
) (
    input  logic        clk,
    input  logic        rstN,
    ctrlBusIf.datapath  ctrl,
    input  logic [7:0]  memRData,
    input  logic        memReady,
    output logic [15:0] memAddr,
    output logic        memWrite,
    output logic [7:0]  memWData,
    output logic [7:0]  accOut,
    output logic [7:0]  xOut,
    output logic [7:0]  yOut
);

    logic [15:0] pc;
    logic [15:0] pcNext;
    logic [7:0]  abl;
    logic [7:0]  abh;
    logic [7:0]  inA;
    logic [7:0]  inB;
    logic [7:0]  aluB;
    logic [7:0]  aluOut;
    logic [7:0]  accReg;
    logic [7:0]  xReg;
    logic [7:0]  yReg;
    logic [7:0]  dataIn;
    logic [7:0]  adl;
    logic [7:0]  adh;
    logic [7:0]  db;
    logic [7:0]  sb;

    // read data only means something with ready
    assign dataIn = memReady ? memRData : 8'h00;

    assign pcNext = pc + {15'd0, ctrl.flags[pcInc]};

    always_comb begin
        if (ctrl.flags[setDbToData]) begin
            db = dataIn;
        end else if (ctrl.flags[setDbToAcc]) begin
            db = accReg;
        end else if (ctrl.flags[setDbToX]) begin
            db = xReg;
        end else if (ctrl.flags[setDbToY]) begin
            db = yReg;
        end else begin
            db = 8'h00;
        end
    end

    // B passes through while it loads but A is only latched
    assign aluB = ctrl.flags[setInputBToDb] ? db : inB;
    assign aluOut = aluB + (ctrl.flags[aluAdd] ? inA : 8'h00) + {7'd0, ctrl.flags[aluInc]};

    always_comb begin
        if (ctrl.flags[setSbToDb]) begin
            sb = db;
        end else if (ctrl.flags[setSbToX]) begin
            sb = xReg;
        end else if (ctrl.flags[setSbToAcc]) begin
            sb = accReg;
        end else if (ctrl.flags[setSbToAlu]) begin
            sb = aluOut;
        end else begin
            sb = 8'h00;
        end
    end

    always_comb begin
        if (ctrl.flags[setAdlToData]) begin
            adl = dataIn;
        end else if (ctrl.flags[setAdlToPcl]) begin
            adl = pcNext[7:0];
        end else if (ctrl.flags[setAdlToAlu]) begin
            adl = aluOut;
        end else begin
            adl = 8'h00;
        end
    end

    always_comb begin
        if (ctrl.flags[setAdhLow]) begin
            adh = 8'h00;
        end else if (ctrl.flags[setAdhToPch]) begin
            adh = pcNext[15:8];
        end else if (ctrl.flags[setAdhToSb]) begin
            adh = sb;
        end else begin
            // idle bus precharges high
            adh = 8'hFF;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
            abl <= resetPc[7:0];
            abh <= resetPc[15:8];
            accReg <= 8'h00;
            xReg <= 8'h00;
            yReg <= 8'h00;
        end else if (ctrl.step) begin
            pc <= pcNext;
            if (ctrl.flags[loadAbl]) abl <= adl;
            if (ctrl.flags[loadAbh]) abh <= adh;
            if (ctrl.flags[loadAcc]) accReg <= sb;
            if (ctrl.flags[loadX]) xReg <= sb;
            if (ctrl.flags[loadY]) yReg <= sb;
        end
    end

    // ALU input latches
    always_ff @(posedge clk) begin
        if (ctrl.step) begin
            if (ctrl.flags[setInputAToSb]) inA <= sb;
            if (ctrl.flags[setInputBToDb]) inB <= db;
        end
    end

    assign memAddr = {abh, abl};
    assign memWrite = ctrl.flags[cpuPkg::memWrite];
    assign memWData = ctrl.flags[cpuPkg::memWrite] ? db : 8'h00;

    assign accOut = accReg;
    assign xOut = xReg;
    assign yOut = yReg;

endmodule

`default_nettype wire

// File: verilog/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
    parameter logic [15:0] resetPc = 16'h0200
) (
    input  logic        clk,
    input  logic        rstN,
    output logic        memValid,
    output logic [15:0] memAddr,
    output logic        memWrite,
    output logic [7:0]  memWData,
    input  logic        memReady,
    input  logic [7:0]  memRData,
    output logic        sync,
    output logic [7:0]  accOut,
    output logic [7:0]  xOut,
    output logic [7:0]  yOut
);

    ctrlBusIf ctrl ();

    cycleSequencer sequencer (
        .clk      (clk),
        .rstN     (rstN),
        .memReady (memReady),
        .memValid (memValid),
        .rdData   (memRData),
        .ctrl     (ctrl.sequencer),
        .sync     (sync)
    );

    addrModeDecode decoder (
        .ctrl (ctrl.decoder)
    );

    busDatapath #(
        .resetPc (resetPc)
    ) datapath (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl.datapath),
        .memRData (memRData),
        .memReady (memReady),
        .memAddr  (memAddr),
        .memWrite (memWrite),
        .memWData (memWData),
        .accOut   (accOut),
        .xOut     (xOut),
        .yOut     (yOut)
    );

endmodule

`default_nettype wire

// File: verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // top index of the control-flag vector
    localparam int numFlags = 26;

    typedef enum logic [4:0] {
        setAdhLow,
        setAdlToData,
        loadAbl,
        loadAbh,
        pcInc,
        setAdlToPcl,
        setAdhToPch,
        setDbToData,
        setInputBToDb,
        setSbToDb,
        setAdlToAlu,
        setAdhToSb,
        setInputAToSb,
        setSbToX,
        aluAdd,
        loadAcc,
        loadX,
        loadY,
        setSbToY,
        setSbToAcc,
        aluInc,
        memWrite,
        lastCycle,
        setSbToAlu,
        setDbToX,
        setDbToY,
        setDbToAcc
    } ctrlFlagE;

    typedef enum logic [2:0] {
        fetch,
        a0,
        a1,
        a2,
        a3
    } cycleStateE;

    typedef enum logic [2:0] {
        implied,
        immediate,
        zeroPage,
        absolute,
        absoluteX
    } addrModeE;

    // standard 6502 encodings
    localparam logic [7:0] opLdaImm = 8'hA9;
    localparam logic [7:0] opLdaZpg = 8'hA5;
    localparam logic [7:0] opLdaAbs = 8'hAD;
    localparam logic [7:0] opLdaAbx = 8'hBD;
    localparam logic [7:0] opLdxImm = 8'hA2;
    localparam logic [7:0] opLdyImm = 8'hA0;
    localparam logic [7:0] opStaZpg = 8'h85;
    localparam logic [7:0] opStaAbs = 8'h8D;
    localparam logic [7:0] opInx    = 8'hE8;
    localparam logic [7:0] opIny    = 8'hC8;
    localparam logic [7:0] opTax    = 8'hAA;
    localparam logic [7:0] opNop    = 8'hEA;

endpackage

`default_nettype wire

// File: verilog/ctrlBusIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrlBusIf import cpuPkg::*; ();

    logic [numFlags:0] flags;
    cycleStateE        state;
    logic [7:0]        opCode;
    // high when the current memory access completes
    logic              step;

    modport sequencer (
        input  flags,
        output state,
        output opCode,
        output step
    );

    modport decoder (
        input  state,
        input  opCode,
        output flags
    );

    modport datapath (
        input flags,
        input state,
        input opCode,
        input step
    );

endinterface

`default_nettype wire

// File: verilog/cycleSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cycleSequencer import cpuPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        memReady,
    output logic        memValid,
    input  logic [7:0]  rdData,
    ctrlBusIf.sequencer ctrl,
    output logic        sync
);

    cycleStateE state;
    logic [7:0] opReg;
    logic       step;

    function automatic cycleStateE nextState(input cycleStateE cur);
        cycleStateE n;
        case (cur)
            fetch:   n = a0;
            a0:      n = a1;
            a1:      n = a2;
            a2:      n = a3;
            default: n = fetch;
        endcase
        return n;
    endfunction

    // a transfer completes when both sides agree
    assign step = memValid & memReady;

    // one idle cycle out of reset, then a request every cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memValid <= 1'b0;
        end else begin
            memValid <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= fetch;
        end else if (step) begin
            if (ctrl.flags[lastCycle]) begin
                state <= fetch;
            end else begin
                state <= nextState(state);
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opReg <= opNop;
        end else if (step && state == fetch) begin
            opReg <= rdData;
        end
    end

    assign sync = memValid && (state == fetch);

    assign ctrl.state = state;
    assign ctrl.opCode = opReg;
    assign ctrl.step = step;

endmodule

`default_nettype wire
